//--- common/gfx_pkg.sv
`default_nettype none

package gfx_pkg;

    localparam int scr_w = 160;
    localparam int scr_h = 120;
    localparam int pix_count = scr_w * scr_h;           // 19200 frame locations

    localparam int queue_depth = 4;                     // Also the drawer's starting credits
    localparam int queue_ptr_w = $clog2(queue_depth);

    typedef logic [7:0]  coord_x_t;
    typedef logic [6:0]  coord_y_t;
    typedef logic [2:0]  colour_t;                      // 3-bit RGB
    typedef logic [7:0]  radius_t;
    typedef logic [14:0] pix_addr_t;
    typedef logic [2:0]  credit_t;                      // Holds 0 to queue_depth

    typedef enum logic [1:0] {
        idle,
        plot,                                           // One octant slot per cycle
        step,                                           // Midpoint update
        drain                                           // Wait for all credits back
    } draw_state_t;

    // Row-major linear address, y * 160 + x
    function automatic pix_addr_t to_addr(input coord_x_t x, input coord_y_t y);
        pix_addr_t row;
        row = pix_addr_t'(y) * pix_addr_t'(scr_w);
        return row + pix_addr_t'(x);
    endfunction

endpackage : gfx_pkg

`default_nettype wire

//--- common/pixel_if.sv
`default_nettype none

interface pixel_if;

    logic              valid;
    gfx_pkg::coord_x_t x;
    gfx_pkg::coord_y_t y;
    gfx_pkg::colour_t  colour;
    logic              credit;                          // Credit pulse or take strobe

    modport sender (
        output valid,
        output x,
        output y,
        output colour,
        input  credit
    );

    modport receiver (
        input  valid,
        input  x,
        input  y,
        input  colour,
        output credit
    );

endinterface : pixel_if

`default_nettype wire

//--- compile.f
common/gfx_pkg.sv
common/pixel_if.sv
rtl/circle/circle_drawer.sv
rtl/framebuffer/pixel_queue.sv
rtl/framebuffer/frame_buffer.sv
rtl/circle_display.sv
sim/tb_circle_display.sv

//--- rtl/circle/circle_drawer.sv
`default_nettype none

module circle_drawer (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  gfx_pkg::colour_t  colour,
    input  gfx_pkg::coord_x_t centre_x,
    input  gfx_pkg::coord_y_t centre_y,
    input  gfx_pkg::radius_t  radius,
    input  logic              ready,
    output logic              done,
    pixel_if.sender           px
);

    gfx_pkg::draw_state_t state;
    gfx_pkg::credit_t     credits;
    logic [2:0]           slot;                         // Which of the eight mirrored points

    gfx_pkg::coord_x_t    cx;
    gfx_pkg::coord_y_t    cy;
    gfx_pkg::colour_t     col;
    logic signed [11:0]   off_x;
    logic signed [11:0]   off_y;
    logic signed [11:0]   dec;                          // Midpoint decision term

    logic signed [11:0]   base_x;
    logic signed [11:0]   base_y;
    logic signed [11:0]   pt_x;
    logic signed [11:0]   pt_y;
    logic signed [11:0]   nxt_x;
    logic signed [11:0]   nxt_y;
    logic signed [11:0]   nxt_d;
    logic                 on_screen;
    logic                 send;
    logic                 advance;

    // Odd slots swap x and y, slots 2..5 mirror x, slots 4..7 mirror y
    always_comb begin
        base_x = slot[0] ? off_y : off_x;
        base_y = slot[0] ? off_x : off_y;
        pt_x = $signed({4'b0, cx}) + ((slot[2] ^ slot[1]) ? -base_x : base_x);
        pt_y = $signed({5'b0, cy}) + (slot[2] ? -base_y : base_y);
    end

    assign on_screen = (pt_x >= 12'sd0) && (pt_x < 12'(gfx_pkg::scr_w)) &&
                       (pt_y >= 12'sd0) && (pt_y < 12'(gfx_pkg::scr_h));

    assign send    = (state == gfx_pkg::plot) && on_screen && (credits != '0);
    assign advance = (state == gfx_pkg::plot) && (!on_screen || (credits != '0));

    assign px.valid  = send;
    assign px.x      = pt_x[7:0];
    assign px.y      = pt_y[6:0];
    assign px.colour = col;

    // Next midpoint values, using the incremented y
    always_comb begin
        nxt_y = off_y + 12'sd1;
        if (dec <= 12'sd0) begin
            nxt_x = off_x;
            nxt_d = dec + (nxt_y <<< 1) + 12'sd1;
        end else begin
            nxt_x = off_x - 12'sd1;
            nxt_d = dec + ((nxt_y - nxt_x) <<< 1) + 12'sd1;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state   <= gfx_pkg::idle;
            credits <= gfx_pkg::credit_t'(gfx_pkg::queue_depth);
            slot    <= '0;
            done    <= 1'b0;
        end else begin
            credits <= credits - gfx_pkg::credit_t'(send) + gfx_pkg::credit_t'(px.credit);
            case (state)
                gfx_pkg::idle: begin
                    if (start && ready) begin
                        state <= gfx_pkg::plot;
                        slot  <= '0;
                        done  <= 1'b0;
                    end
                end
                gfx_pkg::plot: begin
                    if (advance) begin
                        slot <= slot + 3'd1;                // Wraps to 0 after slot 7
                        if (slot == 3'd7)
                            state <= gfx_pkg::step;
                    end
                end
                gfx_pkg::step: begin
                    state <= (nxt_y <= nxt_x) ? gfx_pkg::plot : gfx_pkg::drain;
                end
                default: begin
                    if (credits == gfx_pkg::credit_t'(gfx_pkg::queue_depth)) begin
                        done  <= 1'b1;                      // Every pixel is in memory
                        state <= gfx_pkg::idle;
                    end
                end
            endcase
        end
    end

    // Job registers and the midpoint datapath
    always_ff @(posedge clk) begin
        if (state == gfx_pkg::idle && start && ready) begin
            cx    <= centre_x;
            cy    <= centre_y;
            col   <= colour;
            off_x <= $signed({4'b0, radius});
            off_y <= 12'sd0;
            dec   <= 12'sd1 - $signed({4'b0, radius});
        end else if (state == gfx_pkg::step) begin
            off_x <= nxt_x;
            off_y <= nxt_y;
            dec   <= nxt_d;
        end
    end

    a_credit_max: assert property (@(posedge clk) disable iff (!rst_n)
        credits <= gfx_pkg::credit_t'(gfx_pkg::queue_depth));

    a_idle_credits_full: assert property (@(posedge clk) disable iff (!rst_n)
        (state == gfx_pkg::idle) |->
            (credits == gfx_pkg::credit_t'(gfx_pkg::queue_depth)));

endmodule : circle_drawer

`default_nettype wire

//--- rtl/circle_display.sv
`default_nettype none

module circle_display (
    input  logic              clk,
    input  logic              rst_n,
    input  logic              start,
    input  gfx_pkg::colour_t  colour,
    input  gfx_pkg::coord_x_t centre_x,
    input  gfx_pkg::coord_y_t centre_y,
    input  gfx_pkg::radius_t  radius,
    output logic              done,
    input  logic              rd_en,
    input  gfx_pkg::coord_x_t rd_x,
    input  gfx_pkg::coord_y_t rd_y,
    output gfx_pkg::colour_t  rd_colour,
    output logic              ready
);

    pixel_if draw_link ();                              // Credit-controlled hop
    pixel_if mem_link ();                               // Take strobe hop

    circle_drawer circle_drawer_i (
        .clk      (clk),
        .rst_n    (rst_n),
        .start    (start),
        .colour   (colour),
        .centre_x (centre_x),
        .centre_y (centre_y),
        .radius   (radius),
        .ready    (ready),
        .done     (done),
        .px       (draw_link.sender)
    );

    pixel_queue pixel_queue_i (
        .clk   (clk),
        .rst_n (rst_n),
        .in    (draw_link.receiver),
        .out   (mem_link.sender)
    );

    frame_buffer frame_buffer_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr        (mem_link.receiver),
        .rd_en     (rd_en),
        .rd_x      (rd_x),
        .rd_y      (rd_y),
        .rd_colour (rd_colour),
        .ready     (ready)
    );

endmodule : circle_display

`default_nettype wire

//--- rtl/framebuffer/frame_buffer.sv
`default_nettype none

module frame_buffer (
    input  logic              clk,
    input  logic              rst_n,
    pixel_if.receiver         wr,
    input  logic              rd_en,
    input  gfx_pkg::coord_x_t rd_x,
    input  gfx_pkg::coord_y_t rd_y,
    output gfx_pkg::colour_t  rd_colour,
    output logic              ready
);

    gfx_pkg::colour_t   mem [gfx_pkg::pix_count];

    gfx_pkg::pix_addr_t clr_addr;                       // Clear sweep position
    gfx_pkg::pix_addr_t wr_addr;
    gfx_pkg::pix_addr_t rd_addr;
    gfx_pkg::colour_t   wr_data;
    logic               take;
    logic               we;

    // Reads win over queued writes
    assign take     = wr.valid && ready && !rd_en;
    assign wr.credit = take;

    assign we      = !ready || take;
    assign wr_addr = ready ? gfx_pkg::to_addr(wr.x, wr.y) : clr_addr;
    assign wr_data = ready ? wr.colour : '0;            // Black during the sweep
    assign rd_addr = gfx_pkg::to_addr(rd_x, rd_y);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            clr_addr <= '0;
            ready    <= 1'b0;
        end else if (!ready) begin
            clr_addr <= clr_addr + 1'b1;
            if (clr_addr == gfx_pkg::pix_addr_t'(gfx_pkg::pix_count - 1))
                ready <= 1'b1;                          // Last address written this cycle
        end
    end

    always_ff @(posedge clk) begin
        if (we)
            mem[wr_addr] <= wr_data;
        if (rd_en)
            rd_colour <= mem[rd_addr];
    end

    a_write_on_screen: assert property (@(posedge clk) disable iff (!rst_n)
        take |-> (wr.x < gfx_pkg::coord_x_t'(gfx_pkg::scr_w)) &&
                 (wr.y < gfx_pkg::coord_y_t'(gfx_pkg::scr_h)));

endmodule : frame_buffer

`default_nettype wire

//--- rtl/framebuffer/pixel_queue.sv
`default_nettype none

module pixel_queue (
    input  logic      clk,
    input  logic      rst_n,
    pixel_if.receiver in,
    pixel_if.sender   out
);

    gfx_pkg::coord_x_t               q_x [gfx_pkg::queue_depth];
    gfx_pkg::coord_y_t               q_y [gfx_pkg::queue_depth];
    gfx_pkg::colour_t                q_colour [gfx_pkg::queue_depth];

    logic [gfx_pkg::queue_ptr_w-1:0] wr_ptr;
    logic [gfx_pkg::queue_ptr_w-1:0] rd_ptr;
    gfx_pkg::credit_t                count;
    logic                            pop;
    logic                            credit_q;

    assign pop = out.credit;                            // Take strobe from the memory

    assign out.valid  = (count != '0);
    assign out.x      = q_x[rd_ptr];
    assign out.y      = q_y[rd_ptr];
    assign out.colour = q_colour[rd_ptr];

    assign in.credit = credit_q;

    always_ff @(posedge clk) begin
        if (in.valid) begin
            q_x[wr_ptr]      <= in.x;
            q_y[wr_ptr]      <= in.y;
            q_colour[wr_ptr] <= in.colour;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            wr_ptr   <= '0;
            rd_ptr   <= '0;
            count    <= '0;
            credit_q <= 1'b0;
        end else begin
            if (in.valid)
                wr_ptr <= wr_ptr + 1'b1;                // Pointers wrap at depth 4
            if (pop)
                rd_ptr <= rd_ptr + 1'b1;
            count    <= count + gfx_pkg::credit_t'(in.valid) - gfx_pkg::credit_t'(pop);
            credit_q <= pop;                            // Credit one cycle after the pop
        end
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!rst_n)
        in.valid |-> (count != gfx_pkg::credit_t'(gfx_pkg::queue_depth)));

endmodule : pixel_queue

`default_nettype wire

//--- sim/tb_circle_display.sv
`default_nettype none

module tb_circle_display;

    typedef struct packed {
        int cx;
        int cy;
        int r;
        int col;
        int rd_noise;                                   // Random reads while drawing
        int restart;                                    // Extra start pulse mid-draw
    } job_t;

    localparam int n_jobs = 9;
    localparam int ready_timeout = 25000;
    localparam int done_timeout = 20000;

    job_t jobs [n_jobs] = '{
        '{80, 60, 40, 2, 0, 0},                         // Centred
        '{10, 60, 30, 1, 0, 0},                         // Left edge
        '{150, 30, 25, 4, 0, 0},                        // Right edge
        '{80, 5, 20, 6, 0, 0},                          // Top edge
        '{100, 115, 15, 7, 0, 0},                       // Bottom edge
        '{20, 100, 0, 5, 0, 0},                         // Single pixel
        '{22, 100, 4, 3, 0, 0},                         // Overlaps the single pixel box
        '{60, 50, 35, 3, 1, 0},
        '{120, 80, 18, 5, 0, 1}
    };

    logic              clk;
    logic              rst_n;
    logic              start;
    gfx_pkg::colour_t  colour;
    gfx_pkg::coord_x_t centre_x;
    gfx_pkg::coord_y_t centre_y;
    gfx_pkg::radius_t  radius;
    logic              done;
    logic              rd_en;
    gfx_pkg::coord_x_t rd_x;
    gfx_pkg::coord_y_t rd_y;
    gfx_pkg::colour_t  rd_colour;
    logic              ready;

    gfx_pkg::colour_t  shadow [gfx_pkg::scr_w][gfx_pkg::scr_h];
    logic [31:0]       lfsr;

    circle_display circle_display_i (
        .clk       (clk),
        .rst_n     (rst_n),
        .start     (start),
        .colour    (colour),
        .centre_x  (centre_x),
        .centre_y  (centre_y),
        .radius    (radius),
        .done      (done),
        .rd_en     (rd_en),
        .rd_x      (rd_x),
        .rd_y      (rd_y),
        .rd_colour (rd_colour),
        .ready     (ready)
    );

    always #10 clk = ~clk;

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic report_failure(input string what);
        $display("%s", what);
        $display("SIMULATION FAILED");
        $fatal(1);
    endtask

    task automatic plot_model(input int x, input int y, input int col);
        if (x >= 0 && x < gfx_pkg::scr_w && y >= 0 && y < gfx_pkg::scr_h)
            shadow[x][y] = gfx_pkg::colour_t'(col);
    endtask

    // Reference midpoint walk over one octant
    task automatic model_circle(input int cx, input int cy, input int r, input int col);
        int ox;
        int oy;
        int d;
        ox = r;
        oy = 0;
        d = 1 - r;
        while (oy <= ox) begin
            plot_model(cx + ox, cy + oy, col);
            plot_model(cx + oy, cy + ox, col);
            plot_model(cx - ox, cy + oy, col);
            plot_model(cx - oy, cy + ox, col);
            plot_model(cx + ox, cy - oy, col);
            plot_model(cx + oy, cy - ox, col);
            plot_model(cx - ox, cy - oy, col);
            plot_model(cx - oy, cy - ox, col);
            oy = oy + 1;
            if (d <= 0) begin
                d = d + 2 * oy + 1;
            end else begin
                ox = ox - 1;
                d = d + 2 * (oy - ox) + 1;
            end
        end
    endtask

    // Entered and left 2 units after a rising edge
    task automatic check_pixel(input int x, input int y);
        gfx_pkg::colour_t got;
        rd_en = 1'b1;
        rd_x = gfx_pkg::coord_x_t'(x);
        rd_y = gfx_pkg::coord_y_t'(y);
        @(posedge clk);
        #2;
        rd_en = 1'b0;
        got = rd_colour;
        assert (got === shadow[x][y]) else
            report_failure($sformatf("Error: rd_colour at (%0d,%0d) expected %h, got %h",
                                     x, y, shadow[x][y], got));
    endtask

    task automatic check_box(input job_t job);
        int x0;
        int x1;
        int y0;
        int y1;
        x0 = (job.cx - job.r < 0) ? 0 : job.cx - job.r;
        x1 = (job.cx + job.r >= gfx_pkg::scr_w) ? gfx_pkg::scr_w - 1 : job.cx + job.r;
        y0 = (job.cy - job.r < 0) ? 0 : job.cy - job.r;
        y1 = (job.cy + job.r >= gfx_pkg::scr_h) ? gfx_pkg::scr_h - 1 : job.cy + job.r;
        for (int y = y0; y <= y1; y++)
            for (int x = x0; x <= x1; x++)
                check_pixel(x, y);
    endtask

    task automatic wait_ready();
        int cycles;
        cycles = 0;
        while (!ready) begin
            if (cycles >= ready_timeout)
                report_failure("Timed out waiting for ready after reset");
            @(posedge clk);
            #2;
            cycles++;
        end
    endtask

    task automatic run_job(input job_t job);
        int cycles;
        centre_x = gfx_pkg::coord_x_t'(job.cx);
        centre_y = gfx_pkg::coord_y_t'(job.cy);
        radius = gfx_pkg::radius_t'(job.r);
        colour = gfx_pkg::colour_t'(job.col);
        start = 1'b1;
        @(posedge clk);
        #2;
        start = 1'b0;
        assert (done === 1'b0) else
            report_failure($sformatf("Error: done expected %h, got %h", 1'b0, done));
        cycles = 0;
        while (!done) begin
            if (cycles >= done_timeout)
                report_failure("Timed out waiting for done");
            if (job.rd_noise != 0) begin
                lfsr = lfsr_next(lfsr);
                rd_en = lfsr[0];
            end
            start = (job.restart != 0) && (cycles == 5);
            if (start) begin
                radius = gfx_pkg::radius_t'(job.r / 2);     // Must not be drawn
                colour = gfx_pkg::colour_t'(7 - job.col);
            end
            @(posedge clk);
            #2;
            cycles++;
        end
        rd_en = 1'b0;
        start = 1'b0;
        model_circle(job.cx, job.cy, job.r, job.col);
        check_box(job);
    endtask

    initial begin
        clk = 1'b0;
        rst_n = 1'b0;
        start = 1'b0;
        colour = '0;
        centre_x = '0;
        centre_y = '0;
        radius = '0;
        rd_en = 1'b0;
        rd_x = '0;
        rd_y = '0;
        lfsr = 32'h72056f6e;
        for (int x = 0; x < gfx_pkg::scr_w; x++)
            for (int y = 0; y < gfx_pkg::scr_h; y++)
                shadow[x][y] = '0;
        repeat (5) @(posedge clk);
        #2;
        rst_n = 1'b1;
        assert (ready === 1'b0) else
            report_failure($sformatf("Error: ready expected %h, got %h", 1'b0, ready));
        assert (done === 1'b0) else
            report_failure($sformatf("Error: done expected %h, got %h", 1'b0, done));
        wait_ready();
        check_pixel(0, 0);
        check_pixel(gfx_pkg::scr_w - 1, gfx_pkg::scr_h - 1);
        for (int i = 0; i < 40; i++)
            check_pixel((i * 37) % gfx_pkg::scr_w, (i * 53) % gfx_pkg::scr_h);
        for (int j = 0; j < n_jobs; j++)
            run_job(jobs[j]);
        $display("SIMULATION PASSED");
        $finish;
    end

endmodule : tb_circle_display

`default_nettype wire
